/* aud_player_top.f */
hdl/aud_pkg.sv
hdl/aud_lrck_gen.sv
hdl/aud_sample_buffer.sv
hdl/aud_gain.sv
hdl/aud_serializer.sv
hdl/aud_player_top.sv
bench/aud_clk_gen.sv
bench/aud_player_tb.sv

/* Bender.yml */
package:
  name: aud_player

sources:
  - hdl/aud_pkg.sv
  - hdl/aud_lrck_gen.sv
  - hdl/aud_sample_buffer.sv
  - hdl/aud_gain.sv
  - hdl/aud_serializer.sv
  - hdl/aud_player_top.sv
  - target: test
    files:
      - bench/aud_clk_gen.sv
      - bench/aud_player_tb.sv

/* bench/aud_player_tb.sv */
`timescale 1ns/1ps

module aud_player_tb;
    import aud_pkg::*;

    localparam int WAIT_LIMIT = 4000;  // Bit clocks allowed for one wait.

    logic                bclk;
    logic                rst_n;
    logic                en;
    logic                valid;
    aud_frame_t          frame;
    logic [VOL_W-1:0]    volume;
    logic                mute;
    logic                credit;
    logic                daclrck;
    logic                dacdat;
    logic                sent_frame;
    logic                overrun;
    logic                underrun;

    aud_frame_t          exp_q[$];
    aud_frame_t          sent_q[$];
    aud_frame_t          line_frame;
    logic [SAMPLE_W-1:0] shift_reg;
    logic [15:0]         lfsr = 16'd56447;
    logic                prev_lrck;
    logic                mute_cfg = 1'b0;
    int                  vol_cfg = VOL_UNITY;
    int                  credits = FIFO_DEPTH;  // Host side view.
    int                  half_pos;
    int                  halves;
    int                  credit_pulses;
    int                  zero_frames;
    int                  errors;
    int                  err_base;
    int                  tests_run;
    int                  tests_failed;

    aud_clk_gen i_clk_gen (
        .o_bclk  (bclk),
        .o_rst_n (rst_n)
    );

    aud_player_top i_dut (
        .i_bclk       (bclk),
        .i_rst_n      (rst_n),
        .i_en         (en),
        .i_valid      (valid),
        .i_frame      (frame),
        .i_volume     (volume),
        .i_mute       (mute),
        .o_credit     (credit),
        .o_daclrck    (daclrck),
        .o_dacdat     (dacdat),
        .o_sent_frame (sent_frame),
        .o_overrun    (overrun),
        .o_underrun   (underrun)
    );

    // ####################
    // Checks
    // ####################

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_frame(input string name, input aud_frame_t got, input aud_frame_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
            errors++;
        end
    endtask

    // ####################
    // Line decoder
    // ####################

    // Runs on the falling edge, where the DUT outputs are settled.
    always @(negedge bclk) begin
        if (!rst_n) begin
            half_pos  = HALF_CYCLES - 1;  // As if a right half just ended.
            prev_lrck = 1'b1;
        end else begin
            if (daclrck !== prev_lrck) begin
                if (half_pos != HALF_CYCLES - 1) begin
                    report_error($sformatf("word clock half lasted %0d bit clocks", half_pos + 1));
                end
                half_pos = 0;
                halves++;
            end else begin
                half_pos++;
                if (half_pos == HALF_CYCLES) report_error("word clock stopped toggling");
            end
            // MSB one clock after the edge, fifteen more bits, zeros elsewhere.
            if (half_pos >= 1 && half_pos <= SAMPLE_W) begin
                shift_reg = {shift_reg[SAMPLE_W-2:0], dacdat};
            end else begin
                check_bit("o_dacdat", dacdat, 1'b0);
            end
            if (half_pos == SAMPLE_W && !daclrck) line_frame.left = shift_reg;
            if (half_pos == SAMPLE_W && daclrck) begin
                line_frame.right = shift_reg;
                if (sent_frame) begin
                    sent_q.push_back(line_frame);
                end else begin
                    check_frame("o_dacdat", line_frame, '0);  // Zero fill.
                    zero_frames++;
                end
            end else if (sent_frame) begin
                report_error("o_sent_frame pulsed away from the last bit of a right half");
            end
            if (credit) begin
                credits++;
                credit_pulses++;
            end
            prev_lrck = daclrck;
        end
    end

    // ####################
    // Host model
    // ####################

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_frame(output aud_frame_t f);
        logic [2*SAMPLE_W-1:0] bits;
        for (int i = 0; i < 2 * SAMPLE_W; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[2*SAMPLE_W-2:0], lfsr[0]};
        end
        f = bits;
    endtask

    // Volume clamps at unity, then sample times volume shifted right by 7.
    function automatic aud_frame_t apply_gain(input aud_frame_t f, input int vol,
                                              input logic mute_on);
        aud_frame_t r;
        int         v;
        v       = (vol > VOL_UNITY) ? VOL_UNITY : vol;
        r.left  = SAMPLE_W'((int'(f.left) * v) >>> 7);
        r.right = SAMPLE_W'((int'(f.right) * v) >>> 7);
        return mute_on ? aud_frame_t'('0) : r;
    endfunction

    // Spends one credit per frame. Always returns just after a rising edge.
    task automatic push_frame(input aud_frame_t f);
        int t;
        t = 0;
        @(posedge bclk);
        while (credits == 0 && t < WAIT_LIMIT) begin
            @(posedge bclk);
            t++;
        end
        if (credits == 0) begin
            report_error("timed out waiting for a credit");
        end else begin
            valid <= 1'b1;
            frame <= f;
            credits--;
            @(posedge bclk);
            valid <= 1'b0;
        end
    endtask

    task automatic queue_frame(input aud_frame_t f);
        exp_q.push_back(apply_gain(f, vol_cfg, mute_cfg));
        push_frame(f);
    endtask

    task automatic wait_halves(input int n);
        int target;
        int t;
        target = halves + n;
        t      = 0;
        while (halves < target && t < WAIT_LIMIT) begin
            @(posedge bclk);
            t++;
        end
        if (halves < target) report_error("timed out waiting for word clock edges");
    endtask

    // All credits home, then every expected frame decoded and compared.
    task automatic drain(input logic stop_en);
        int t;
        t = 0;
        @(posedge bclk);
        while (credits != FIFO_DEPTH && t < WAIT_LIMIT) begin
            @(posedge bclk);
            t++;
        end
        if (credits != FIFO_DEPTH) report_error("timed out waiting for the buffer to drain");
        if (stop_en) en <= 1'b0;  // Lands well before the next frame load.
        t = 0;
        while (sent_q.size() < exp_q.size() && t < WAIT_LIMIT) begin
            @(posedge bclk);
            t++;
        end
        if (sent_q.size() < exp_q.size()) report_error("timed out waiting for frames on the line");
        while (exp_q.size() > 0 && sent_q.size() > 0) begin
            check_frame("o_dacdat frame", sent_q.pop_front(), exp_q.pop_front());
        end
        exp_q.delete();
    endtask

    task automatic stream(input int n);
        aud_frame_t f;
        for (int i = 0; i < n; i++) begin
            rand_frame(f);
            queue_frame(f);
            if (i == FIFO_DEPTH - 1 || i == n - 1) en <= 1'b1;
        end
        drain(1'b1);
    endtask

    task automatic set_gain(input int vol, input logic mute_on);
        @(posedge bclk);
        volume   <= VOL_W'(vol);
        mute     <= mute_on;
        vol_cfg  = vol;
        mute_cfg = mute_on;
        @(posedge bclk);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_base) begin
            $display("[%s] ok", name);
        end else begin
            tests_failed++;
            $display("[%s] %0d errors", name, errors - err_base);
        end
        err_base = errors;
    endtask

    // ####################
    // Tests
    // ####################

    task automatic reset_state();
        wait_halves(4);
        if (credit_pulses != 0) report_error("credit pulses arrived after reset");
        if (sent_q.size() != 0) report_error("frames were sent with an empty buffer");
        @(negedge bclk);
        check_bit("o_overrun", overrun, 1'b0);
        check_bit("o_underrun", underrun, 1'b0);
        finish_test("reset_state");
    endtask

    task automatic unity_playback();
        int base;
        base = credit_pulses;
        stream(6);
        if (credit_pulses - base != 6) report_error("wrong number of credits for 6 frames");
        finish_test("unity_playback");
    endtask

    task automatic gain_and_mute();
        set_gain(64, 1'b0);
        stream(4);
        set_gain(200, 1'b0);
        stream(4);
        set_gain(VOL_UNITY, 1'b1);
        stream(3);
        set_gain(VOL_UNITY, 1'b0);
        finish_test("gain_and_mute");
    endtask

    task automatic credit_flow();
        aud_frame_t f;
        int         base;
        base = credit_pulses;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            rand_frame(f);
            queue_frame(f);
        end
        if (credits != 0) report_error("host still holds credits with the buffer full");
        wait_halves(2);
        if (credit_pulses != base) report_error("credit returned with nothing popped");
        en <= 1'b1;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            rand_frame(f);
            queue_frame(f);
            if (credits != 0) report_error("one credit let more than one frame through");
        end
        drain(1'b1);
        if (credit_pulses - base != 2 * FIFO_DEPTH) report_error("credit count off after draining");
        @(negedge bclk);
        check_bit("o_overrun", overrun, 1'b0);
        check_bit("o_underrun", underrun, 1'b0);
        finish_test("credit_flow");
    endtask

    task automatic error_flags();
        aud_frame_t f;
        int         zero_base;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            rand_frame(f);
            queue_frame(f);
        end
        rand_frame(f);  // Fifth frame, written with no credit.
        valid <= 1'b1;
        frame <= f;
        @(posedge bclk);
        valid <= 1'b0;
        @(negedge bclk);
        check_bit("o_overrun", overrun, 1'b1);
        @(posedge bclk);
        en <= 1'b1;
        drain(1'b0);
        zero_base = zero_frames;
        wait_halves(4);
        if (sent_q.size() != 0) report_error("the dropped frame reached the line");
        if (zero_frames == zero_base) report_error("no zero frames sent while starved");
        @(negedge bclk);
        check_bit("o_underrun", underrun, 1'b1);
        @(posedge bclk);
        en <= 1'b0;
        finish_test("error_flags");
    endtask

    task automatic enable_low();
        aud_frame_t f;
        int         base;
        int         zero_base;
        for (int i = 0; i < 3; i++) begin
            rand_frame(f);
            queue_frame(f);
        end
        base      = credit_pulses;
        zero_base = zero_frames;
        wait_halves(6);
        if (sent_q.size() != 0) report_error("frames were sent with the player disabled");
        if (credit_pulses != base) report_error("frames popped with the player disabled");
        if (zero_frames - zero_base < 2) report_error("line did not carry zeros while disabled");
        en <= 1'b1;
        drain(1'b1);
        finish_test("enable_low");
    endtask

    initial begin
        int t;
        en     = 1'b0;
        valid  = 1'b0;
        frame  = '0;
        volume = VOL_W'(VOL_UNITY);
        mute   = 1'b0;
        t      = 0;
        while (rst_n !== 1'b1 && t < WAIT_LIMIT) begin
            @(posedge bclk);
            t++;
        end
        if (rst_n !== 1'b1) report_error("reset was never released");
        reset_state();
        unity_playback();
        gain_and_mute();
        credit_flow();
        error_flags();
        enable_low();
        $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* bench/aud_clk_gen.sv */
`timescale 1ns/1ps

module aud_clk_gen (
    output logic o_bclk,
    output logic o_rst_n
);
    localparam int RESET_CYCLES = 8;

    // 20 ns bit clock.
    initial begin
        o_bclk = 1'b0;
        forever #10 o_bclk = ~o_bclk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_bclk);
        o_rst_n <= 1'b1;
    end

endmodule

/* hdl/aud_player_top.sv */
`timescale 1ns/1ps

module aud_player_top (
    input  logic                        i_bclk,
    input  logic                        i_rst_n,
    input  logic                        i_en,
    input  logic                        i_valid,
    input  aud_pkg::aud_frame_t         i_frame,
    input  logic [aud_pkg::VOL_W-1:0]   i_volume,
    input  logic                        i_mute,
    output logic                        o_credit,
    output logic                        o_daclrck,
    output logic                        o_dacdat,
    output logic                        o_sent_frame,
    output logic                        o_overrun,
    output logic                        o_underrun
);
    import aud_pkg::*;

    lrck_pos_t  pos;
    aud_frame_t head;
    aud_frame_t gained;
    logic       not_empty;
    logic       pop;

    aud_lrck_gen i_lrck_gen (
        .i_bclk      (i_bclk),
        .i_rst_n     (i_rst_n),
        .o_daclrck   (o_daclrck),
        .o_pos       (pos)
    );

    aud_sample_buffer i_buffer (
        .i_bclk      (i_bclk),
        .i_rst_n     (i_rst_n),
        .i_valid     (i_valid),
        .i_frame     (i_frame),
        .i_pop       (pop),
        .o_head      (head),
        .o_not_empty (not_empty),
        .o_credit    (o_credit),
        .o_overrun   (o_overrun)
    );

    aud_gain i_gain (
        .i_bclk      (i_bclk),
        .i_rst_n     (i_rst_n),
        .i_frame     (head),
        .i_volume    (i_volume),
        .i_mute      (i_mute),
        .o_frame     (gained)
    );

    aud_serializer i_serializer (
        .i_bclk       (i_bclk),
        .i_rst_n      (i_rst_n),
        .i_en         (i_en),
        .i_pos        (pos),
        .i_frame      (gained),
        .i_not_empty  (not_empty),
        .o_pop        (pop),
        .o_dacdat     (o_dacdat),
        .o_sent_frame (o_sent_frame),
        .o_underrun   (o_underrun)
    );

endmodule

/* hdl/aud_serializer.sv */
`timescale 1ns/1ps

module aud_serializer (
    input  logic                  i_bclk,
    input  logic                  i_rst_n,
    input  logic                  i_en,
    input  aud_pkg::lrck_pos_t    i_pos,
    input  aud_pkg::aud_frame_t   i_frame,
    input  logic                  i_not_empty,
    output logic                  o_pop,
    output logic                  o_dacdat,
    output logic                  o_sent_frame,
    output logic                  o_underrun
);
    import aud_pkg::*;

    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(SAMPLE_W - 1);

    aud_frame_t frame_r;
    logic       live_r;       // Current frame is real data, not zero fill.
    logic       not_empty_q;
    logic       dacdat_r;
    logic       sent_r;
    logic       underrun_r;

    logic                load;
    logic                starve;
    logic [SAMPLE_W-1:0] sample;
    logic [SAMPLE_W-1:0] shifted;

    // ####################
    // Frame load
    // ####################

    // Gain output trails the head by one cycle, so look at last cycle's fill.
    always_ff @(posedge i_bclk) begin
        if (!i_rst_n) begin
            not_empty_q <= 1'b0;
        end else begin
            not_empty_q <= i_not_empty;
        end
    end

    assign load   = i_pos.frame_load && i_en && not_empty_q;
    assign starve = i_pos.frame_load && i_en && !not_empty_q;
    assign o_pop  = load;

    always_ff @(posedge i_bclk) begin
        if (!i_rst_n) begin
            frame_r    <= '0;
            live_r     <= 1'b0;
            underrun_r <= 1'b0;
        end else if (i_pos.frame_load) begin
            if (load) begin
                frame_r <= i_frame;
                live_r  <= 1'b1;
            end else begin
                frame_r <= '0;    // Disabled or starved.
                live_r  <= 1'b0;
            end
            if (starve) begin
                underrun_r <= 1'b1;
            end
        end
    end

    // ####################
    // Bit shifting
    // ####################

    assign sample = i_pos.channel ? frame_r.right : frame_r.left;

    // Past the last sample bit everything shifts out, leaving zeros.
    assign shifted = sample << i_pos.bit_pos;

    // Registered, so each bit lands one clock after the word-clock edge.
    always_ff @(posedge i_bclk) begin
        if (!i_rst_n) begin
            dacdat_r <= 1'b0;
            sent_r   <= 1'b0;
        end else begin
            dacdat_r <= shifted[SAMPLE_W-1];
            sent_r   <= live_r && i_pos.channel && (i_pos.bit_pos == LAST_BIT);
        end
    end

    assign o_dacdat     = dacdat_r;
    assign o_sent_frame = sent_r;
    assign o_underrun   = underrun_r;

endmodule

/* hdl/aud_gain.sv */
`timescale 1ns/1ps

module aud_gain (
    input  logic                        i_bclk,
    input  logic                        i_rst_n,
    input  aud_pkg::aud_frame_t         i_frame,
    input  logic [aud_pkg::VOL_W-1:0]   i_volume,
    input  logic                        i_mute,
    output aud_pkg::aud_frame_t         o_frame
);
    import aud_pkg::*;

    localparam logic [VOL_W-1:0] VOL_MAX = VOL_W'(VOL_UNITY);

    logic [VOL_W-1:0] vol;
    aud_frame_t       scaled;
    aud_frame_t       frame_r;

    // ####################
    // Scaling
    // ####################

    // Sample times volume, then arithmetic shift back down.
    function automatic logic signed [SAMPLE_W-1:0] scale (
        input logic signed [SAMPLE_W-1:0] sample,
        input logic [VOL_W-1:0]           volume
    );
        logic signed [SAMPLE_W+VOL_W:0] prod;
        logic signed [VOL_W:0]          vol_s;
        vol_s = $signed({1'b0, volume});
        prod  = sample * vol_s;
        return prod[GAIN_SHIFT +: SAMPLE_W];
    endfunction

    assign vol = (i_volume > VOL_MAX) ? VOL_MAX : i_volume;  // Never boost.

    always_comb begin
        if (i_mute) begin
            scaled = '0;
        end else begin
            scaled.left  = scale(i_frame.left, vol);
            scaled.right = scale(i_frame.right, vol);
        end
    end

    // ####################
    // Output register
    // ####################

    // Follows the head one cycle later.
    always_ff @(posedge i_bclk) begin
        if (!i_rst_n) begin
            frame_r <= '0;
        end else begin
            frame_r <= scaled;
        end
    end

    assign o_frame = frame_r;

endmodule

/* hdl/aud_sample_buffer.sv */
`timescale 1ns/1ps

module aud_sample_buffer (
    input  logic                  i_bclk,
    input  logic                  i_rst_n,
    input  logic                  i_valid,
    input  aud_pkg::aud_frame_t   i_frame,
    input  logic                  i_pop,
    output aud_pkg::aud_frame_t   o_head,
    output logic                  o_not_empty,
    output logic                  o_credit,
    output logic                  o_overrun
);
    import aud_pkg::*;

    localparam logic [PTR_W-1:0]  LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [FILL_W-1:0] FULL      = FILL_W'(FIFO_DEPTH);

    aud_frame_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_r;
    logic [PTR_W-1:0]  rd_ptr_r;
    logic [FILL_W-1:0] fill_r;
    logic              credit_r;
    logic              overrun_r;

    logic full;
    logic do_wr;
    logic do_rd;

    assign full  = (fill_r == FULL);
    assign do_wr = i_valid && !full;   // Frames arriving without room are dropped.
    assign do_rd = i_pop && o_not_empty;

    // ####################
    // Storage
    // ####################

    always_ff @(posedge i_bclk) begin
        if (do_wr) begin
            mem[wr_ptr_r] <= i_frame;
        end
    end

    // First-word fall-through.
    assign o_head      = mem[rd_ptr_r];
    assign o_not_empty = (fill_r != '0);

    // ####################
    // Pointers and fill
    // ####################

    always_ff @(posedge i_bclk) begin
        if (!i_rst_n) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            fill_r   <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_r <= (wr_ptr_r == LAST_SLOT) ? '0 : wr_ptr_r + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_r <= (rd_ptr_r == LAST_SLOT) ? '0 : rd_ptr_r + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   fill_r <= fill_r + 1'b1;
                2'b01:   fill_r <= fill_r - 1'b1;
                default: fill_r <= fill_r;
            endcase
        end
    end

    // Credit goes back to the host the cycle after each pop.
    always_ff @(posedge i_bclk) begin
        if (!i_rst_n) begin
            credit_r  <= 1'b0;
            overrun_r <= 1'b0;
        end else begin
            credit_r <= do_rd;
            if (i_valid && full) begin
                overrun_r <= 1'b1;  // Sticky.
            end
        end
    end

    assign o_credit  = credit_r;
    assign o_overrun = overrun_r;

endmodule

/* hdl/aud_lrck_gen.sv */
`timescale 1ns/1ps

module aud_lrck_gen (
    input  logic                  i_bclk,
    input  logic                  i_rst_n,
    output logic                  o_daclrck,
    output aud_pkg::lrck_pos_t    o_pos
);
    import aud_pkg::*;

    localparam logic [CNT_W-1:0] LAST_STEP = '1;

    logic [CNT_W-1:0] cnt_r;

    // ####################
    // Free-running counter
    // ####################

    // Wraps on its own after 2*HALF_CYCLES steps.
    always_ff @(posedge i_bclk) begin
        if (!i_rst_n) begin
            cnt_r <= '0;
        end else begin
            cnt_r <= cnt_r + 1'b1;
        end
    end

    // Top bit is the word clock, low for left.
    assign o_daclrck = cnt_r[CNT_W-1];

    // ####################
    // Position decode
    // ####################

    always_comb begin
        o_pos.channel    = cnt_r[CNT_W-1];
        o_pos.bit_pos    = cnt_r[BIT_W-1:0];
        o_pos.frame_load = (cnt_r == LAST_STEP);  // Next step starts a left half.
    end

endmodule

/* hdl/aud_pkg.sv */
package aud_pkg;

    // ####################
    // Sizes
    // ####################

    localparam int SAMPLE_W    = 16;
    localparam int HALF_CYCLES = 32;                   // Bit clocks per word-clock half.
    localparam int BIT_W       = $clog2(HALF_CYCLES);  // Position within one half.
    localparam int CNT_W       = BIT_W + 1;            // Whole word-clock period.

    localparam int FIFO_DEPTH  = 4;                    // Also the host's starting credits.
    localparam int PTR_W       = $clog2(FIFO_DEPTH);
    localparam int FILL_W      = $clog2(FIFO_DEPTH + 1);

    localparam int VOL_W       = 8;
    localparam int VOL_UNITY   = 128;
    localparam int GAIN_SHIFT  = $clog2(VOL_UNITY);    // Unity volume maps to a shift of 7.

    // ####################
    // Types
    // ####################

    // One stereo sample frame, left word in the upper half.
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] left;
        logic signed [SAMPLE_W-1:0] right;
    } aud_frame_t;

    // Where the word clock currently stands.
    typedef struct packed {
        logic             channel;     // 0 left, 1 right.
        logic [BIT_W-1:0] bit_pos;
        logic             frame_load;  // Last cycle before a left half.
    } lrck_pos_t;

endpackage
